/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_cpu
FILELIST  = project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^=== PASS ===$$'

clean:
	rm -rf obj_dir

/* alu.sv */
// 32-bit ALU
// and, or, add, addu, signed and unsigned set-less-than, shift left,
// subtract, plus a zero flag on the result
`timescale 1ns/1ps

module alu (
	input  cpu_pkg::alu_ctrl_t ctrl,
	input  cpu_pkg::word_t     a,
	input  cpu_pkg::word_t     b,
	input  logic [4:0]         shamt,
	output cpu_pkg::word_t     result,
	output logic               zero
);

	logic lt_signed;
	logic lt_unsigned;

	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (ctrl)
			3'd0:    result = a & b;
			3'd1:    result = a | b;
			3'd2:    result = a + b;
			3'd3:    result = {31'b0, lt_signed};
			// no overflow trap, so addu matches add
			3'd4:    result = a + b;
			3'd5:    result = b << shamt;
			3'd6:    result = a - b;
			3'd7:    result = {31'b0, lt_unsigned};
			default: result = '0;
		endcase
	end

	assign zero = result == '0;

endmodule

/* control.sv */
// main decoder
// turns opcode and funct into datapath controls, the ALU control code
// and the taken/not-taken branch decision
`timescale 1ns/1ps

module control (
	input  cpu_pkg::opcode_t   opcode,
	input  cpu_pkg::funct_t    funct,
	input  logic               zero,
	input  logic               sign,
	output logic               reg_wr,
	output logic               reg_dst,
	output logic               ext_op,
	output logic               alu_src,
	output logic               mem_wr,
	output logic               mem_rd,
	output logic               mem_to_reg,
	output cpu_pkg::alu_ctrl_t alu_ctrl,
	output logic               npc_sel,
	output logic               halt
);

	// one-hot function vector
	// [14] add [13] addi [12] addu [11] sub [10] subu [9] and [8] or [7] sll
	// [6] lw [5] sw [4] beq [3] bne [2] bgtz [1] slt [0] sltu
	logic [14:0] fn;
	logic        alu_or, alu_add, alu_slt;
	logic        alu_addu, alu_sll, alu_sub, alu_sltu;

	always_comb begin
		fn = '0;
		case (opcode)
			cpu_pkg::OP_RTYPE: begin
				case (funct)
					cpu_pkg::FN_ADD:  fn[14] = 1'b1;
					cpu_pkg::FN_ADDU: fn[12] = 1'b1;
					cpu_pkg::FN_SUB:  fn[11] = 1'b1;
					cpu_pkg::FN_SUBU: fn[10] = 1'b1;
					cpu_pkg::FN_AND:  fn[9]  = 1'b1;
					cpu_pkg::FN_OR:   fn[8]  = 1'b1;
					cpu_pkg::FN_SLL:  fn[7]  = 1'b1;
					cpu_pkg::FN_SLT:  fn[1]  = 1'b1;
					cpu_pkg::FN_SLTU: fn[0]  = 1'b1;
					default:          fn     = '0;
				endcase
			end
			cpu_pkg::OP_ADDI: fn[13] = 1'b1;
			cpu_pkg::OP_LW:   fn[6]  = 1'b1;
			cpu_pkg::OP_SW:   fn[5]  = 1'b1;
			cpu_pkg::OP_BEQ:  fn[4]  = 1'b1;
			cpu_pkg::OP_BNE:  fn[3]  = 1'b1;
			cpu_pkg::OP_BGTZ: fn[2]  = 1'b1;
			// unknown opcodes fall through as no-ops
			default:          fn     = '0;
		endcase
	end

	// every function except stores and branches writes back
	assign reg_wr     = |{fn[14:6], fn[1:0]};
	assign reg_dst    = opcode == cpu_pkg::OP_RTYPE;
	assign alu_src    = fn[13] | fn[6] | fn[5];
	// sign extend for addi, memory offsets and branch offsets
	assign ext_op     = fn[13] | fn[6] | fn[5] | fn[4] | fn[3] | fn[2];
	assign mem_wr     = fn[5];
	assign mem_rd     = fn[6];
	assign mem_to_reg = fn[6];
	assign halt       = opcode == cpu_pkg::OP_HALT;

	// group functions by ALU operation
	assign alu_or   = fn[8];
	assign alu_add  = fn[14] | fn[13] | fn[6] | fn[5];
	assign alu_slt  = fn[1];
	assign alu_addu = fn[12];
	assign alu_sll  = fn[7];
	assign alu_sub  = fn[11] | fn[10] | fn[4] | fn[3] | fn[2];
	assign alu_sltu = fn[0];

	// binary encode, and maps to 000 by default
	assign alu_ctrl[0] = alu_or | alu_slt | alu_sll | alu_sltu;
	assign alu_ctrl[1] = alu_add | alu_slt | alu_sub | alu_sltu;
	assign alu_ctrl[2] = alu_addu | alu_sll | alu_sub | alu_sltu;

	// bgtz compares rs against r0, so result > 0 means not zero and not negative
	assign npc_sel = (fn[4] & zero) | (fn[3] & ~zero) | (fn[2] & ~zero & ~sign);

endmodule

/* cpu.sv */
// single-cycle MIPS subset core
// datapath muxes, immediate extension and a Wishbone master that
// stretches lw/sw until the data memory acks
`timescale 1ns/1ps

module cpu (
	input  logic              clk,
	input  logic              rst,
	input  logic              prog_we,
	input  cpu_pkg::pc_t      prog_addr,
	input  cpu_pkg::word_t    prog_data,
	input  cpu_pkg::reg_idx_t dbg_idx,
	output cpu_pkg::word_t    dbg_data,
	output logic              halted
);

	cpu_pkg::word_t     inst;
	cpu_pkg::opcode_t   opcode;
	cpu_pkg::funct_t    funct;
	cpu_pkg::reg_idx_t  rs, rt, rd, rw;
	logic [4:0]         shamt;
	logic [15:0]        imm16;
	cpu_pkg::word_t     imm32;

	logic               reg_wr, reg_dst, ext_op, alu_src;
	logic               mem_wr, mem_rd, mem_to_reg, npc_sel, halt;
	cpu_pkg::alu_ctrl_t alu_ctrl;
	logic               zero, sign;

	cpu_pkg::word_t     bus_a, bus_b, bus_w, alu_b, alu_result;
	logic               mem_op, stall;

	cpu_pkg::mem_state_t state;
	logic               wb_cyc, wb_stb, wb_we, wb_ack;
	cpu_pkg::word_t     wb_adr, wb_dat_w, wb_dat_r;

	// instruction fields
	assign opcode = inst[31:26];
	assign rs     = inst[25:21];
	assign rt     = inst[20:16];
	assign rd     = inst[15:11];
	assign shamt  = inst[10:6];
	assign funct  = inst[5:0];
	assign imm16  = inst[15:0];

	assign imm32 = ext_op ? {{16{imm16[15]}}, imm16} : {16'b0, imm16};

	fetch_inst u_fetch (
		.clk       (clk),
		.rst       (rst),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.imm32     (imm32),
		.npc_sel   (npc_sel),
		.stall     (stall),
		.halt      (halt),
		.inst      (inst)
	);

	control u_control (
		.opcode     (opcode),
		.funct      (funct),
		.zero       (zero),
		.sign       (sign),
		.reg_wr     (reg_wr),
		.reg_dst    (reg_dst),
		.ext_op     (ext_op),
		.alu_src    (alu_src),
		.mem_wr     (mem_wr),
		.mem_rd     (mem_rd),
		.mem_to_reg (mem_to_reg),
		.alu_ctrl   (alu_ctrl),
		.npc_sel    (npc_sel),
		.halt       (halt)
	);

	assign rw = reg_dst ? rd : rt;

	// lw writes back only on the ack cycle
	registers u_regs (
		.clk      (clk),
		.rst      (rst),
		.we       (reg_wr & ~stall),
		.ra       (rs),
		.rb       (rt),
		.rw       (rw),
		.bus_w    (bus_w),
		.bus_a    (bus_a),
		.bus_b    (bus_b),
		.dbg_idx  (dbg_idx),
		.dbg_data (dbg_data)
	);

	assign alu_b = alu_src ? imm32 : bus_b;

	alu u_alu (
		.ctrl   (alu_ctrl),
		.a      (bus_a),
		.b      (alu_b),
		.shamt  (shamt),
		.result (alu_result),
		.zero   (zero)
	);

	assign sign  = alu_result[31];
	assign bus_w = mem_to_reg ? wb_dat_r : alu_result;

	// memory access FSM, one bus cycle per lw/sw
	assign mem_op = mem_rd | mem_wr;
	assign stall  = mem_op & ~wb_ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cpu_pkg::MS_IDLE;
		end else begin
			case (state)
				cpu_pkg::MS_IDLE: if (mem_op) state <= cpu_pkg::MS_WAIT;
				cpu_pkg::MS_WAIT: if (wb_ack) state <= cpu_pkg::MS_IDLE;
				default:          state <= cpu_pkg::MS_IDLE;
			endcase
		end
	end

	// address and data stay stable since the pc holds during the access
	assign wb_cyc   = state == cpu_pkg::MS_WAIT;
	assign wb_stb   = state == cpu_pkg::MS_WAIT;
	assign wb_we    = mem_wr;
	assign wb_adr   = alu_result;
	assign wb_dat_w = bus_b;

	d_mem u_dmem (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	// pc sits on the halt word, so decode keeps this high until reset
	assign halted = halt;

endmodule

/* cpu_golden.txt */
# P <byte address hex> <instruction hex> | R <register hex> <expected value hex>
# C <cycle limit decimal>; text after the values is ignored
P 00 20010007  addi r1, r0, 7
P 04 2002FFFD  addi r2, r0, -3
P 08 00221820  add  r3, r1, r2
P 0C 00222021  addu r4, r1, r2
P 10 00222822  sub  r5, r1, r2
P 14 00413023  subu r6, r2, r1
P 18 00223824  and  r7, r1, r2
P 1C 00224025  or   r8, r1, r2
P 20 00014900  sll  r9, r1, 4
P 24 0041502A  slt  r10, r2, r1
P 28 0041582B  sltu r11, r2, r1
P 2C AC050008  sw   r5, 8(r0)
P 30 8C0C0008  lw   r12, 8(r0)
P 34 10640001  beq  r3, r4, +1 taken
P 38 200D0001  addi r13 skipped
P 3C 200E0002  addi r14 runs
P 40 10220001  beq  r1, r2, +1 not taken
P 44 200F0003  addi r15 runs
P 48 14220001  bne  r1, r2, +1 taken
P 4C 20100004  addi r16 skipped
P 50 14640001  bne  r3, r4, +1 not taken
P 54 20110005  addi r17 runs
P 58 1C200001  bgtz r1, +1 taken
P 5C 20120006  addi r18 skipped
P 60 1C400001  bgtz r2, +1 not taken
P 64 20130007  addi r19 runs
P 68 FC000000  halt
P 6C 20140009  addi r20 after halt
R 01 00000007
R 02 FFFFFFFD
R 03 00000004
R 04 00000004
R 05 0000000A
R 06 FFFFFFF6
R 07 00000005
R 08 FFFFFFFF
R 09 00000070
R 0A 00000001
R 0B 00000000
R 0C 0000000A
R 0D 00000000
R 0E 00000002
R 0F 00000003
R 10 00000000
R 11 00000005
R 12 00000000
R 13 00000007
R 14 00000000
C 200

/* cpu_pkg.sv */
// cpu shared definitions
// word, index and field types, MIPS opcode and funct encodings,
// ALU control codes and memory sizing for the single-cycle core
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] pc_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;

	// 0 and, 1 or, 2 add, 3 slt, 4 addu, 5 sll, 6 sub, 7 sltu
	typedef logic [2:0]  alu_ctrl_t;

	// opcode field
	localparam opcode_t OP_RTYPE = 6'b000000;
	localparam opcode_t OP_ADDI  = 6'b001000;
	localparam opcode_t OP_LW    = 6'b100011;
	localparam opcode_t OP_SW    = 6'b101011;
	localparam opcode_t OP_BEQ   = 6'b000100;
	localparam opcode_t OP_BNE   = 6'b000101;
	localparam opcode_t OP_BGTZ  = 6'b000111;
	localparam opcode_t OP_HALT  = 6'b111111;

	// funct field of R-type
	localparam funct_t FN_ADD  = 6'b100000;
	localparam funct_t FN_ADDU = 6'b100001;
	localparam funct_t FN_SUB  = 6'b100010;
	localparam funct_t FN_SUBU = 6'b100011;
	localparam funct_t FN_AND  = 6'b100100;
	localparam funct_t FN_OR   = 6'b100101;
	localparam funct_t FN_SLL  = 6'b000000;
	localparam funct_t FN_SLT  = 6'b101010;
	localparam funct_t FN_SLTU = 6'b101011;

	// memories, word addressed by byte address bits [AW+1:2]
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam int IMEM_AW    = $clog2(IMEM_WORDS);
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	// data memory wait states before ack
	localparam int MEM_WAIT = 2;
	localparam int WAIT_W   = $clog2(MEM_WAIT + 1);
	typedef logic [WAIT_W-1:0] wait_cnt_t;

	typedef enum logic {
		MS_IDLE,
		MS_WAIT
	} mem_state_t;

endpackage

/* d_mem.sv */
// data memory, Wishbone classic slave
// holds off ack for a fixed number of wait states, then acks for one cycle;
// writes land on the ack edge and read data is valid with ack
`timescale 1ns/1ps

module d_mem (
	input  logic           clk,
	input  logic           rst,
	input  logic           wb_cyc,
	input  logic           wb_stb,
	input  logic           wb_we,
	input  cpu_pkg::word_t wb_adr,
	input  cpu_pkg::word_t wb_dat_w,
	output cpu_pkg::word_t wb_dat_r,
	output logic           wb_ack
);

	cpu_pkg::word_t      dmem [cpu_pkg::DMEM_WORDS];
	cpu_pkg::wait_cnt_t  wait_cnt;
	logic                req;
	logic [cpu_pkg::DMEM_AW-1:0] idx;

	assign req = wb_cyc & wb_stb;
	assign idx = wb_adr[cpu_pkg::DMEM_AW+1:2];

	// wait counter, ack goes high MEM_WAIT cycles after stb is first seen
	always_ff @(posedge clk) begin
		if (rst) begin
			wait_cnt <= '0;
			wb_ack   <= 1'b0;
		end else if (req && !wb_ack) begin
			if (wait_cnt == cpu_pkg::wait_cnt_t'(cpu_pkg::MEM_WAIT - 1)) begin
				wb_ack   <= 1'b1;
				wait_cnt <= '0;
			end else begin
				wait_cnt <= wait_cnt + cpu_pkg::wait_cnt_t'(1);
			end
		end else begin
			// ack is a single pulse, also clears when stb drops
			wb_ack   <= 1'b0;
			wait_cnt <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (req && wb_we && wb_ack) begin
			dmem[idx] <= wb_dat_w;
		end
	end

	assign wb_dat_r = dmem[idx];

endmodule

/* fetch_inst.sv */
// instruction fetch
// program counter and instruction memory; memory is loaded through
// the program port while reset is held
`timescale 1ns/1ps

module fetch_inst (
	input  logic           clk,
	input  logic           rst,
	input  logic           prog_we,
	input  cpu_pkg::pc_t   prog_addr,
	input  cpu_pkg::word_t prog_data,
	input  cpu_pkg::word_t imm32,
	input  logic           npc_sel,
	input  logic           stall,
	input  logic           halt,
	output cpu_pkg::word_t inst
);

	cpu_pkg::word_t imem [cpu_pkg::IMEM_WORDS];
	cpu_pkg::pc_t   pc;
	cpu_pkg::pc_t   pc_plus4;
	cpu_pkg::pc_t   pc_branch;

	assign pc_plus4  = pc + 32'd4;
	// branch offset counts words from the delay-free pc+4
	assign pc_branch = pc_plus4 + (imm32 << 2);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (!stall && !halt) begin
			pc <= npc_sel ? pc_branch : pc_plus4;
		end
	end

	// program load only while in reset
	always_ff @(posedge clk) begin
		if (rst && prog_we) begin
			imem[prog_addr[cpu_pkg::IMEM_AW+1:2]] <= prog_data;
		end
	end

	assign inst = imem[pc[cpu_pkg::IMEM_AW+1:2]];

endmodule

/* project.f */
cpu_pkg.sv
alu.sv
registers.sv
control.sv
fetch_inst.sv
d_mem.sv
cpu.sv
tb_cpu.sv

/* registers.sv */
// register file
// 32 x 32 bits, two async read ports, one sync write port, debug read port
`timescale 1ns/1ps

module registers (
	input  logic              clk,
	input  logic              rst,
	input  logic              we,
	input  cpu_pkg::reg_idx_t ra,
	input  cpu_pkg::reg_idx_t rb,
	input  cpu_pkg::reg_idx_t rw,
	input  cpu_pkg::word_t    bus_w,
	output cpu_pkg::word_t    bus_a,
	output cpu_pkg::word_t    bus_b,
	input  cpu_pkg::reg_idx_t dbg_idx,
	output cpu_pkg::word_t    dbg_data
);

	cpu_pkg::word_t regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rw != '0) begin
			regs[rw] <= bus_w;
		end
	end

	// r0 always reads zero
	assign bus_a    = (ra == '0) ? '0 : regs[ra];
	assign bus_b    = (rb == '0) ? '0 : regs[rb];
	assign dbg_data = (dbg_idx == '0) ? '0 : regs[dbg_idx];

endmodule

/* tb_cpu.sv */
// testbench for the single-cycle core
// loads the program from the golden file during reset, runs to halt,
// then reads back registers through the debug port and compares
`timescale 1ns/1ps

module tb_cpu;

	logic              clk;
	logic              rst;
	logic              prog_we;
	cpu_pkg::pc_t      prog_addr;
	cpu_pkg::word_t    prog_data;
	cpu_pkg::reg_idx_t dbg_idx;
	cpu_pkg::word_t    dbg_data;
	logic              halted;

	// contents of the golden file
	cpu_pkg::pc_t      load_addr_q[$];
	cpu_pkg::word_t    load_data_q[$];
	cpu_pkg::reg_idx_t exp_idx_q[$];
	cpu_pkg::word_t    exp_val_q[$];
	int                cycle_limit = 0;
	int                errors = 0;

	cpu DUT (
		.clk       (clk),
		.rst       (rst),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.dbg_idx   (dbg_idx),
		.dbg_data  (dbg_data),
		.halted    (halted)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic check_word(input string name, input cpu_pkg::word_t got,
			input cpu_pkg::word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED t=%0t %s expected %b got %b", $time, name, exp, got);
			errors++;
		end
	endtask

	// P addr data, R idx value, C limit; anything else is a comment
	task automatic read_golden();
		int          fd;
		int          code;
		int          n;
		int          want;
		string       line;
		string       rest;
		byte         kind;
		logic [31:0] a;
		logic [31:0] b;
		fd = $fopen("cpu_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open cpu_golden.txt for reading");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2) begin
				continue;
			end
			kind = line.getc(0);
			rest = line.substr(1, line.len() - 1);
			case (kind)
				"P": begin
					n = $sscanf(rest, "%h %h", a, b);
					want = 2;
					load_addr_q.push_back(a);
					load_data_q.push_back(b);
				end
				"R": begin
					n = $sscanf(rest, "%h %h", a, b);
					want = 2;
					exp_idx_q.push_back(cpu_pkg::reg_idx_t'(a));
					exp_val_q.push_back(b);
				end
				"C": begin
					n = $sscanf(rest, "%d", cycle_limit);
					want = 1;
				end
				default: begin
					n = 0;
					want = 0;
				end
			endcase
			if (n != want) begin
				$display("malformed line in golden file: %s", line);
				errors++;
			end
		end
		$fclose(fd);
	endtask

	initial begin
		int cycles;
		rst       = 1'b1;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		dbg_idx   = '0;
		read_golden();

		// reset clears the register file
		repeat (3) @(posedge clk);

		// program load is only accepted while reset is high
		foreach (load_addr_q[i]) begin
			@(posedge clk);
			prog_we   <= 1'b1;
			prog_addr <= load_addr_q[i];
			prog_data <= load_data_q[i];
		end
		@(posedge clk);
		prog_we <= 1'b0;

		for (int i = 0; i < 32; i++) begin
			@(posedge clk);
			dbg_idx <= cpu_pkg::reg_idx_t'(i);
			@(negedge clk);
			check_word($sformatf("dbg_data r%0d after reset", i), dbg_data, '0);
		end
		check_flag("halted after reset", halted, 1'b0);
		@(posedge clk);
		rst <= 1'b0;

		cycles = 0;
		@(negedge clk);
		while (!halted && cycles < cycle_limit) begin
			@(negedge clk);
			cycles++;
		end

		if (!halted) begin
			$display("timeout: halted did not rise within %0d cycles", cycle_limit);
			errors++;
		end else begin
			// halt must stick
			repeat (5) @(negedge clk);
			check_flag("halted after stop", halted, 1'b1);
			foreach (exp_idx_q[i]) begin
				@(posedge clk);
				dbg_idx <= exp_idx_q[i];
				@(negedge clk);
				check_word($sformatf("dbg_data r%0d", exp_idx_q[i]), dbg_data, exp_val_q[i]);
			end
		end

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
